//--- vlog.f
logic/fetch_pkg.sv
logic/predecode.sv
logic/mem_arbiter.sv
logic/unified_mem.sv
logic/ifu.sv
logic/fetch_top.sv
dv/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the fetch stage testbench with verilator
# exit status is non-zero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
top=fetch_tb

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert \
	-Mdir "$build_dir" \
	--top-module "$top" \
	-f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

if [ ! -x "./$build_dir/V$top" ]; then
	echo "simulation binary ./$build_dir/V$top is missing"
	exit 1
fi

"./$build_dir/V$top"
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation ended with status $status"
	exit "$status"
fi

echo "simulation ended with status 0"
exit 0

//--- dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

	import fetch_pkg::*;

	// ********************
	// run shape
	// ********************

	localparam logic [xlen-1:0] reset_pc = 64'h8000_0000;
	localparam int mem_aw = 10;

	localparam int reset_cycles = 8;
	localparam int load_len     = 64;
	localparam int seq_len      = 40;
	localparam int bp_len       = 40;
	localparam int redir_len    = 24;
	localparam int arb_len      = 24;
	// twice the nominal run length
	localparam int timeout_cycles =
		2 * (reset_cycles + load_len + seq_len + bp_len + redir_len + arb_len);

	logic            clk = 1'b0;
	logic            rst_n;
	logic            pc_update;
	logic [xlen-1:0] dnpc;
	logic            ready_if_id;
	data_req_t       data_req;
	mem_word_u       data_rdata;
	logic            data_gnt;
	logic            valid_if_id;
	if_id_t          if_id;
	logic            branch_flush;

	integer seed = 32'h010a0cd4;
	int     cycle_count = 0;

	// model of memory contents, same index rule as the DUT
	logic [63:0] mirror [2**mem_aw];

	// previous-cycle view, sampled on each rising edge
	logic            prev_live = 1'b0;
	logic            prev_accept = 1'b0;
	logic            prev_hold = 1'b0;
	logic            prev_redirect = 1'b0;
	logic            prev_data = 1'b0;
	logic            first_done = 1'b0;
	logic [xlen-1:0] prev_pc;
	logic [xlen-1:0] prev_dnpc;
	inst_t           prev_inst;

	// expected values for the current cycle
	logic [63:0] fetch_word;
	logic [63:0] data_word;
	inst_t       exp_inst;
	br_class_e   exp_class;

	fetch_top #(
		.reset_pc(reset_pc),
		.mem_aw  (mem_aw)
	) u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.pc_update   (pc_update),
		.dnpc        (dnpc),
		.ready_if_id (ready_if_id),
		.data_req    (data_req),
		.data_rdata  (data_rdata),
		.data_gnt    (data_gnt),
		.valid_if_id (valid_if_id),
		.if_id       (if_id),
		.branch_flush(branch_flush)
	);

	always #2 clk = ~clk;

	// ********************
	// helpers
	// ********************

	task automatic stop_with_failure();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		stop_with_failure();
	endtask

	// classification straight from the opcode table
	function automatic br_class_e expected_class(input inst_t word);
		logic [6:0] opc;
		logic [2:0] f3;
		opc = word[6:0];
		f3 = word[14:12];
		if (opc == op_jal)
			return br_jal;
		if (opc == op_jalr && f3 == 3'b000)
			return br_jalr;
		// 010 and 011 are not branches
		if (opc == op_branch && f3 != 3'b010 && f3 != 3'b011)
			return br_cond;
		if (word == inst_ecall || word == inst_mret)
			return br_sys;
		return br_none;
	endfunction

	// random word with planted control flow every few slots
	function automatic inst_t program_inst(input int k, input logic [31:0] rnd);
		case (k % 9)
			1: return 32'h0080_006f;
			3: return 32'h0000_80e7;
			4: return 32'h0020_8463;
			5: return inst_ecall;
			6: return inst_mret;
			// beq shape with funct3 010
			7: return 32'h0020_a463;
			default: return rnd;
		endcase
	endfunction

	// doubleword inside the loaded program region
	function automatic logic [63:0] region_addr(input logic [5:0] slot);
		return reset_pc + {55'd0, slot, 3'b000};
	endfunction

	task automatic write_dword(input logic [63:0] addr, input logic [63:0] word);
		data_req.req = 1'b1;
		data_req.we = 1'b1;
		data_req.addr = addr;
		data_req.wdata.dword = word;
	endtask

	task automatic read_dword(input logic [63:0] addr);
		data_req.req = 1'b1;
		data_req.we = 1'b0;
		data_req.addr = addr;
		data_req.wdata.dword = 64'd0;
	endtask

	task automatic release_port();
		data_req = '0;
	endtask

	// ********************
	// reference model
	// ********************

	// write lands on the edge where it is requested
	always @(posedge clk) begin
		if (data_req.req && data_req.we)
			mirror[data_req.addr[mem_aw+2:3]] <= data_req.wdata.dword;
	end

	assign fetch_word = mirror[if_id.pc[mem_aw+2:3]];
	assign data_word  = mirror[data_req.addr[mem_aw+2:3]];
	assign exp_inst   = if_id.pc[2] ? fetch_word[63:32] : fetch_word[31:0];
	assign exp_class  = expected_class(exp_inst);

	always @(posedge clk) begin
		prev_live     <= rst_n;
		prev_pc       <= if_id.pc;
		prev_inst     <= if_id.inst;
		prev_dnpc     <= dnpc;
		prev_accept   <= valid_if_id && ready_if_id && !pc_update;
		prev_hold     <= !ready_if_id && !data_req.req;
		prev_redirect <= ready_if_id && pc_update;
		prev_data     <= data_req.req;
		if (rst_n && !data_req.req)
			first_done <= 1'b1;
	end

	// run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: run still going after %0d cycles", timeout_cycles);
			stop_with_failure();
		end
	end

	// ********************
	// checks
	// ********************

	a_reset_valid: assert property (@(posedge clk) !rst_n |-> !valid_if_id)
		else report_mismatch("valid_if_id", 64'd0, 64'($sampled(valid_if_id)));
	a_first_pc: assert property (@(posedge clk)
			(rst_n && !first_done && !data_req.req) |-> if_id.pc == reset_pc)
		else report_mismatch("if_id.pc", reset_pc, $sampled(if_id.pc));
	a_valid: assert property (@(posedge clk) rst_n |-> valid_if_id == !data_req.req)
		else report_mismatch("valid_if_id", 64'(!$sampled(data_req.req)),
			64'($sampled(valid_if_id)));
	a_step: assert property (@(posedge clk)
			(rst_n && prev_live && prev_accept) |-> if_id.pc == prev_pc + 64'd4)
		else report_mismatch("if_id.pc", $sampled(prev_pc) + 64'd4, $sampled(if_id.pc));
	a_inst: assert property (@(posedge clk) (rst_n && valid_if_id) |-> if_id.inst == exp_inst)
		else report_mismatch("if_id.inst", 64'($sampled(exp_inst)), 64'($sampled(if_id.inst)));
	a_class: assert property (@(posedge clk)
			(rst_n && valid_if_id) |-> if_id.br_class == exp_class)
		else report_mismatch("if_id.br_class", 64'($sampled(exp_class)),
			64'($sampled(if_id.br_class)));
	// back-pressure, nothing moves
	a_hold_pc: assert property (@(posedge clk)
			(rst_n && prev_live && prev_hold && !data_req.req) |-> if_id.pc == prev_pc)
		else report_mismatch("if_id.pc", $sampled(prev_pc), $sampled(if_id.pc));
	a_hold_inst: assert property (@(posedge clk)
			(rst_n && prev_live && prev_hold && !data_req.req) |-> if_id.inst == prev_inst)
		else report_mismatch("if_id.inst", 64'($sampled(prev_inst)),
			64'($sampled(if_id.inst)));
	a_flush: assert property (@(posedge clk) branch_flush == pc_update)
		else report_mismatch("branch_flush", 64'($sampled(pc_update)),
			64'($sampled(branch_flush)));
	a_redirect: assert property (@(posedge clk)
			(rst_n && prev_live && prev_redirect) |-> if_id.pc == prev_dnpc)
		else report_mismatch("if_id.pc", $sampled(prev_dnpc), $sampled(if_id.pc));
	a_gnt: assert property (@(posedge clk) data_gnt == data_req.req)
		else report_mismatch("data_gnt", 64'($sampled(data_req.req)),
			64'($sampled(data_gnt)));
	// fetch stalls while the data port owns memory
	a_data_hold: assert property (@(posedge clk)
			(rst_n && prev_live && prev_data && !prev_redirect) |-> if_id.pc == prev_pc)
		else report_mismatch("if_id.pc", $sampled(prev_pc), $sampled(if_id.pc));
	a_rdata: assert property (@(posedge clk)
			(data_req.req && !data_req.we) |-> data_rdata.dword == data_word)
		else report_mismatch("data_rdata", $sampled(data_word),
			$sampled(data_rdata.dword));

	// ********************
	// stimulus
	// ********************

	initial begin
		logic [31:0] rnd;
		logic [31:0] rnd2;
		int          stretch;
		rst_n = 1'b0;
		pc_update = 1'b0;
		dnpc = '0;
		ready_if_id = 1'b1;
		data_req = '0;

		// program load, starts under reset and keeps fetch stalled
		for (int i = 0; i < load_len; i++) begin
			@(negedge clk);
			if (i == reset_cycles - 1)
				rst_n = 1'b1;
			rnd = program_inst(2 * i, $random(seed));
			rnd2 = program_inst(2 * i + 1, $random(seed));
			write_dword(region_addr(6'(i)), {rnd2, rnd});
		end

		// straight-line fetch
		for (int i = 0; i < seq_len; i++) begin
			@(negedge clk);
			release_port();
		end

		// back-pressure in random stretches
		stretch = 0;
		for (int i = 0; i < bp_len; i++) begin
			@(negedge clk);
			if (stretch == 0) begin
				rnd = $random(seed);
				ready_if_id = ~ready_if_id;
				stretch = 1 + int'(rnd[2:0]);
			end
			stretch--;
		end

		// redirects, some blocked by ready, some under a data read
		for (int i = 0; i < redir_len; i++) begin
			@(negedge clk);
			rnd = $random(seed);
			ready_if_id = (i % 5 != 4);
			pc_update = (i % 3 == 0);
			dnpc = reset_pc + {56'd0, rnd[5:0], 2'b00};
			if (i % 6 == 0)
				read_dword(region_addr(rnd[13:8]));
			else
				release_port();
		end
		@(negedge clk);
		pc_update = 1'b0;
		ready_if_id = 1'b1;

		// data traffic, then a store to the fetched word
		for (int i = 0; i < arb_len; i++) begin
			@(negedge clk);
			rnd = $random(seed);
			rnd2 = $random(seed);
			case (i % 4)
				0: read_dword(region_addr(rnd[5:0]));
				1: write_dword(region_addr(rnd[5:0]), {rnd2, rnd});
				2: write_dword({if_id.pc[63:3], 3'b000}, {rnd, rnd2});
				default: release_port();
			endcase
		end

		@(negedge clk);
		release_port();
		repeat (4) @(negedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
	parameter logic [fetch_pkg::xlen-1:0] reset_pc = 64'h8000_0000,
	parameter int                         mem_aw   = 10
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       pc_update,
	input  logic [fetch_pkg::xlen-1:0] dnpc,
	input  logic                       ready_if_id,
	input  fetch_pkg::data_req_t       data_req,
	output fetch_pkg::mem_word_u       data_rdata,
	output logic                       data_gnt,
	output logic                       valid_if_id,
	output fetch_pkg::if_id_t          if_id,
	output logic                       branch_flush
);

	import fetch_pkg::*;

	// current pc, also the fetch address
	logic [xlen-1:0] pc;
	// selected instruction half
	inst_t           inst;
	// predecode result
	br_class_e       br_class;
	// arbiter to memory
	mem_req_t        mem_req;
	// fetch owns the port this cycle
	logic            fetch_gnt;

	// ********************
	// fetch unit
	// ********************

	ifu #(
		.reset_pc(reset_pc)
	) u_ifu (
		.clk         (clk),
		.rst_n       (rst_n),
		.dnpc        (dnpc),
		.pc_update   (pc_update),
		.ready_if_id (ready_if_id),
		.fetch_gnt   (fetch_gnt),
		.rdata       (data_rdata),
		.pc          (pc),
		.inst        (inst),
		.valid_if_id (valid_if_id),
		.branch_flush(branch_flush)
	);

	predecode u_predecode (
		.inst    (inst),
		.br_class(br_class)
	);

	// record for decode
	assign if_id = '{pc: pc, inst: inst, br_class: br_class};

	// ********************
	// memory side
	// ********************

	mem_arbiter u_mem_arbiter (
		.data_req  (data_req),
		.fetch_addr(pc),
		.mem_req   (mem_req),
		.data_gnt  (data_gnt),
		.fetch_gnt (fetch_gnt)
	);

	// read data goes to both the fetch unit and the data port
	unified_mem #(
		.mem_aw(mem_aw)
	) u_unified_mem (
		.clk    (clk),
		.mem_req(mem_req),
		.rdata  (data_rdata)
	);

endmodule

//--- logic/ifu.sv
`timescale 1ns/1ps

module ifu #(
	parameter logic [fetch_pkg::xlen-1:0] reset_pc = 64'h8000_0000
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [fetch_pkg::xlen-1:0] dnpc,
	input  logic                       pc_update,
	input  logic                       ready_if_id,
	input  logic                       fetch_gnt,
	input  fetch_pkg::mem_word_u       rdata,
	output logic [fetch_pkg::xlen-1:0] pc,
	output fetch_pkg::inst_t           inst,
	output logic                       valid_if_id,
	output logic                       branch_flush
);

	import fetch_pkg::*;

	// sequential successor of the current pc
	logic [xlen-1:0] seq_pc;
	// value loaded at the next edge
	logic [xlen-1:0] pc_next;

	assign seq_pc = pc + xlen'(4);

	// ********************
	// next pc selection
	// ********************

	// nothing moves while decode is full
	// redirect beats the sequential step
	// redirect is taken even without the memory port,
	// the instruction at the old pc is dropped anyway
	always_comb begin
		pc_next = pc;
		if (ready_if_id) begin
			if (pc_update) begin
				pc_next = dnpc;
			end else if (fetch_gnt) begin
				// only step once the word was really read
				pc_next = seq_pc;
			end
		end
	end

	// ********************
	// pc register
	// ********************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
		end else begin
			pc <= pc_next;
		end
	end

	// ********************
	// instruction select
	// ********************

	// upper half for pc[2] set, lower half otherwise
	assign inst = rdata.half[pc[2]];

	// record is good whenever fetch owns the port
	// forced low while the core is held in reset
	assign valid_if_id = fetch_gnt & rst_n;

	// later stages flush on their own redirect
	assign branch_flush = pc_update;

endmodule

//--- logic/unified_mem.sv
`timescale 1ns/1ps

module unified_mem #(
	parameter int mem_aw = 10
) (
	input  logic                 clk,
	input  fetch_pkg::mem_req_t  mem_req,
	output fetch_pkg::mem_word_u rdata
);

	import fetch_pkg::*;

	// number of doublewords
	localparam int depth = 2 ** mem_aw;

	// ********************
	// storage
	// ********************

	mem_word_u mem [depth];

	// doubleword index
	// bits 2:0 pick a byte inside the word, upper bits alias
	logic [mem_aw-1:0] idx;

	assign idx = mem_req.addr[mem_aw+2:3];

	// ********************
	// read port
	// ********************

	// same cycle read, fetch depends on it for zero latency
	assign rdata = mem[idx];

	// ********************
	// write port
	// ********************

	// full dword store, no byte enables
	// new data visible to the read in the following cycle
	always_ff @(posedge clk) begin
		if (mem_req.we) begin
			mem[idx] <= mem_req.wdata;
		end
	end

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  fetch_pkg::data_req_t       data_req,
	input  logic [fetch_pkg::xlen-1:0] fetch_addr,
	output fetch_pkg::mem_req_t        mem_req,
	output logic                       data_gnt,
	output logic                       fetch_gnt
);

	// ********************
	// grant
	// ********************

	// data side always wins, fetch gets every idle cycle
	// purely combinational, nothing is queued
	assign data_gnt  = data_req.req;
	assign fetch_gnt = ~data_req.req;

	// ********************
	// port mux
	// ********************

	// address of the winner
	assign mem_req.addr = data_req.req ? data_req.addr : fetch_addr;

	// fetch only reads
	// store needs both req and we
	assign mem_req.we = data_req.req & data_req.we;

	// write data only matters with we set,
	// so it comes from the data side unconditionally
	assign mem_req.wdata = data_req.wdata;

endmodule

//--- logic/predecode.sv
`timescale 1ns/1ps

module predecode (
	input  fetch_pkg::inst_t     inst,
	output fetch_pkg::br_class_e br_class
);

	import fetch_pkg::*;

	// fields used for classification
	logic [6:0] opcode;
	logic [2:0] funct3;
	// branch funct3 is one of the six defined encodings
	logic       cond_ok;
	// word is exactly ecall or mret
	logic       sys_hit;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];

	// ********************
	// field checks
	// ********************

	// 010 and 011 are reserved for branches
	always_comb begin
		case (funct3)
			// beq
			3'b000: cond_ok = 1'b1;
			// bne
			3'b001: cond_ok = 1'b1;
			// blt
			3'b100: cond_ok = 1'b1;
			// bge
			3'b101: cond_ok = 1'b1;
			// bltu
			3'b110: cond_ok = 1'b1;
			// bgeu
			3'b111: cond_ok = 1'b1;
			default: cond_ok = 1'b0;
		endcase
	end

	// other system words (csr ops, wfi, ebreak) stay plain
	assign sys_hit = (inst == inst_ecall) || (inst == inst_mret);

	// ********************
	// class select
	// ********************

	always_comb begin
		br_class = br_none;
		case (opcode)
			op_jal: begin
				// no funct3 in a J-type word
				br_class = br_jal;
			end
			op_jalr: begin
				// jalr only defines funct3 000
				if (funct3 == 3'b000) begin
					br_class = br_jalr;
				end
			end
			op_branch: begin
				if (cond_ok) begin
					br_class = br_cond;
				end
			end
			op_system: begin
				if (sys_hit) begin
					br_class = br_sys;
				end
			end
			default: begin
				br_class = br_none;
			end
		endcase
	end

endmodule

//--- logic/fetch_pkg.sv
package fetch_pkg;

	// ********************
	// widths and words
	// ********************

	// address and data width of the core
	localparam int xlen = 64;

	// one uncompressed instruction
	typedef logic [31:0] inst_t;

	// one memory doubleword
	// data port sees the full dword
	// fetch path sees two instructions, half index is addr bit 2
	typedef union packed {
		logic [xlen-1:0] dword;
		inst_t [1:0]     half;
	} mem_word_u;

	// ********************
	// branch classes
	// ********************

	// tag attached to every fetched instruction
	// br_sys covers ecall and mret only
	typedef enum logic [2:0] {
		br_none = 3'd0,
		br_jal  = 3'd1,
		br_jalr = 3'd2,
		br_cond = 3'd3,
		br_sys  = 3'd4
	} br_class_e;

	// ********************
	// stage records
	// ********************

	// record handed to decode
	typedef struct packed {
		logic [xlen-1:0] pc;
		inst_t           inst;
		br_class_e       br_class;
	} if_id_t;

	// request from the load/store side
	// req is a level, held for as long as the access lasts
	typedef struct packed {
		logic            req;
		logic            we;
		logic [xlen-1:0] addr;
		mem_word_u       wdata;
	} data_req_t;

	// single memory port after arbitration
	typedef struct packed {
		logic [xlen-1:0] addr;
		logic            we;
		mem_word_u       wdata;
	} mem_req_t;

	// ********************
	// opcodes
	// ********************

	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_system = 7'b1110011;

	// full system words, compared as a whole
	localparam inst_t inst_ecall = 32'h0000_0073;
	localparam inst_t inst_mret  = 32'h3020_0073;

endpackage
